//--- logic/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define DATA_W          32
`define REG_AW          5
`define NUM_REGS        32

// also the credits fetch holds after reset
`define ISSUE_DEPTH     4

`define LINK_REG        1

// jirl, then b, bl, beq, bne, blt, bge, bltu, bgeu follow in order
`define OPC_BR_BASE     6'h13
`define OPC_LU12I       6'h05
`define OPC_PCADDU12I   6'h07

`endif

//--- logic/decode_pkg.sv
package decode_pkg;

    // alu operation handed to execute
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_NOR,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI      // passes source 2
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_JIRL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_kind_t;

endpackage

//--- logic/regfile.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module regfile (
    input  logic               clk,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    input  logic               we,
    input  logic [`REG_AW-1:0] waddr,
    input  logic [`DATA_W-1:0] wdata,
    output logic [`DATA_W-1:0] rdata1,
    output logic [`DATA_W-1:0] rdata2
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, write-back bypassed to both ports
    assign rdata1 = (raddr1 == '0)                ? '0    :
                    (we && waddr == raddr1)       ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0)                ? '0    :
                    (we && waddr == raddr2)       ? wdata : regs[raddr2];

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module inst_decoder import decode_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  logic [31:0]        in_inst,
    input  logic [`DATA_W-1:0] in_pc,
    output logic               dec_valid,
    output logic [`DATA_W-1:0] dec_pc,
    output alu_op_t            dec_op,
    output br_kind_t           dec_br,
    output logic [`REG_AW-1:0] dec_rj,
    output logic [`REG_AW-1:0] dec_rkd_addr,
    output logic               dec_src1_is_pc,
    output logic               dec_src2_is_imm,
    output logic [`DATA_W-1:0] dec_imm,
    output logic [`DATA_W-1:0] dec_br_offs,
    output logic [`REG_AW-1:0] dec_dest,
    output logic               dec_rf_we,
    output logic               dec_ine
);

    logic [31:0]        inst;
    logic [5:0]         opc;
    logic [3:0]         op_25_22;
    logic [1:0]         op_21_20;
    logic [4:0]         op_19_15;
    logic [4:0]         rd;
    logic [4:0]         rk;
    logic [11:0]        i12;
    logic [19:0]        i20;
    logic [15:0]        i16;
    logic [25:0]        i26;
    logic [`DATA_W-1:0] si12;
    logic [`DATA_W-1:0] ui12;
    logic [`DATA_W-1:0] ui5;
    logic [`DATA_W-1:0] si20;
    logic [`DATA_W-1:0] offs16;
    logic [`DATA_W-1:0] offs26;
    logic               illegal;
    logic               rkd_is_rd;
    logic               dest_is_link;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            inst   <= in_inst;
            dec_pc <= in_pc;
        end
    end

    assign opc      = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};   // offs[25:16] sits in the low bits

    assign si12   = {{(`DATA_W-12){i12[11]}}, i12};
    assign ui12   = {{(`DATA_W-12){1'b0}}, i12};
    assign ui5    = {{(`DATA_W-5){1'b0}}, rk};
    assign si20   = {i20, 12'b0};
    assign offs16 = {{(`DATA_W-18){i16[15]}}, i16, 2'b0};
    assign offs26 = {{(`DATA_W-28){i26[25]}}, i26, 2'b0};

    always_comb begin
        dec_op          = OP_ADD;
        dec_br          = BR_NONE;
        dec_src1_is_pc  = 1'b0;
        dec_src2_is_imm = 1'b0;
        dec_imm         = '0;
        dec_br_offs     = offs16;
        dec_rf_we       = 1'b1;
        illegal         = 1'b0;
        rkd_is_rd       = 1'b0;
        dest_is_link    = 1'b0;
        case (opc)
            6'h00: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    case (op_19_15)    // three-register forms
                        5'h00: dec_op = OP_ADD;
                        5'h02: dec_op = OP_SUB;
                        5'h04: dec_op = OP_SLT;
                        5'h05: dec_op = OP_SLTU;
                        5'h08: dec_op = OP_NOR;
                        5'h09: dec_op = OP_AND;
                        5'h0a: dec_op = OP_OR;
                        5'h0b: dec_op = OP_XOR;
                        5'h0e: dec_op = OP_SLL;
                        5'h0f: dec_op = OP_SRL;
                        5'h10: dec_op = OP_SRA;
                        default: illegal = 1'b1;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    dec_src2_is_imm = 1'b1;
                    dec_imm         = ui5;
                    case (op_19_15)
                        5'h01: dec_op = OP_SLL;
                        5'h09: dec_op = OP_SRL;
                        5'h11: dec_op = OP_SRA;
                        default: illegal = 1'b1;
                    endcase
                end else begin
                    dec_src2_is_imm = 1'b1;
                    dec_imm         = si12;
                    case (op_25_22)
                        4'h8: dec_op = OP_SLT;
                        4'h9: dec_op = OP_SLTU;
                        4'ha: dec_op = OP_ADD;
                        default: illegal = 1'b1;
                    endcase
                    // logic immediates are zero extended
                    if (op_25_22 == 4'hd || op_25_22 == 4'he || op_25_22 == 4'hf) begin
                        illegal = 1'b0;
                        dec_imm = ui12;
                        dec_op  = (op_25_22 == 4'hd) ? OP_AND :
                                  (op_25_22 == 4'he) ? OP_OR : OP_XOR;
                    end
                end
            end
            `OPC_LU12I: begin
                dec_op          = OP_LUI;
                dec_src2_is_imm = 1'b1;
                dec_imm         = si20;
                illegal         = inst[25];
            end
            `OPC_PCADDU12I: begin
                dec_src1_is_pc  = 1'b1;
                dec_src2_is_imm = 1'b1;
                dec_imm         = si20;
                illegal         = inst[25];
            end
            `OPC_BR_BASE: begin
                dec_br          = BR_JIRL;
                dec_src1_is_pc  = 1'b1;   // link value pc + 4
                dec_src2_is_imm = 1'b1;
                dec_imm         = `DATA_W'(4);
            end
            `OPC_BR_BASE + 6'd1: begin
                dec_br      = BR_B;
                dec_br_offs = offs26;
                dec_rf_we   = 1'b0;
            end
            `OPC_BR_BASE + 6'd2: begin
                dec_br          = BR_BL;
                dec_br_offs     = offs26;
                dec_src1_is_pc  = 1'b1;
                dec_src2_is_imm = 1'b1;
                dec_imm         = `DATA_W'(4);
                dest_is_link    = 1'b1;
            end
            `OPC_BR_BASE + 6'd3: dec_br = BR_BEQ;
            `OPC_BR_BASE + 6'd4: dec_br = BR_BNE;
            `OPC_BR_BASE + 6'd5: dec_br = BR_BLT;
            `OPC_BR_BASE + 6'd6: dec_br = BR_BGE;
            `OPC_BR_BASE + 6'd7: dec_br = BR_BLTU;
            `OPC_BR_BASE + 6'd8: dec_br = BR_BGEU;
            default: illegal = 1'b1;
        endcase

        // conditional branches compare rj against rd
        if (dec_br inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU}) begin
            rkd_is_rd = 1'b1;
            dec_rf_we = 1'b0;
        end

        if (illegal) begin
            dec_op          = OP_ADD;
            dec_src1_is_pc  = 1'b0;
            dec_src2_is_imm = 1'b0;
            dec_rf_we       = 1'b0;
        end
    end

    assign dec_ine      = illegal;
    assign dec_rj       = inst[9:5];
    assign dec_rkd_addr = rkd_is_rd ? rd : rk;
    assign dec_dest     = dest_is_link ? `REG_AW'(`LINK_REG) : rd;

endmodule

//--- logic/operand_stage.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module operand_stage import decode_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               dec_valid,
    input  logic [`DATA_W-1:0] dec_pc,
    input  alu_op_t            dec_op,
    input  br_kind_t           dec_br,
    input  logic [`REG_AW-1:0] dec_rj,
    input  logic [`REG_AW-1:0] dec_rkd_addr,
    input  logic               dec_src1_is_pc,
    input  logic               dec_src2_is_imm,
    input  logic [`DATA_W-1:0] dec_imm,
    input  logic [`DATA_W-1:0] dec_br_offs,
    input  logic [`REG_AW-1:0] dec_dest,
    input  logic               dec_rf_we,
    input  logic               dec_ine,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_addr,
    input  logic [`DATA_W-1:0] wb_data,
    output logic               br_valid,
    output logic [`DATA_W-1:0] br_target,
    output logic               op_valid,
    output alu_op_t            op_op,
    output logic [`DATA_W-1:0] op_src1,
    output logic [`DATA_W-1:0] op_src2,
    output logic [`DATA_W-1:0] op_rkd,
    output logic [`REG_AW-1:0] op_dest,
    output logic               op_rf_we,
    output logic [`DATA_W-1:0] op_pc,
    output logic               op_ine
);

    logic [`DATA_W-1:0] rj_value;
    logic [`DATA_W-1:0] rkd_value;
    logic               rj_eq_rkd;
    logic               rj_lt_rkd;
    logic               rj_ltu_rkd;
    logic               taken;
    logic [`DATA_W-1:0] target;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec_rj),
        .raddr2 (dec_rkd_addr),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    assign rj_eq_rkd  = rj_value == rkd_value;
    assign rj_lt_rkd  = $signed(rj_value) < $signed(rkd_value);
    assign rj_ltu_rkd = rj_value < rkd_value;

    always_comb begin
        case (dec_br)
            BR_B, BR_BL, BR_JIRL: taken = 1'b1;
            BR_BEQ:  taken = rj_eq_rkd;
            BR_BNE:  taken = !rj_eq_rkd;
            BR_BLT:  taken = rj_lt_rkd;
            BR_BGE:  taken = !rj_lt_rkd;
            BR_BLTU: taken = rj_ltu_rkd;
            BR_BGEU: taken = !rj_ltu_rkd;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, all others pc relative
    assign target = ((dec_br == BR_JIRL) ? rj_value : dec_pc) + dec_br_offs;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            op_valid <= 1'b0;
            br_valid <= 1'b0;
        end else begin
            op_valid <= dec_valid;
            br_valid <= dec_valid && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            op_op     <= dec_op;
            op_src1   <= dec_src1_is_pc ? dec_pc : rj_value;
            op_src2   <= dec_src2_is_imm ? dec_imm : rkd_value;
            op_rkd    <= rkd_value;
            op_dest   <= dec_dest;
            op_rf_we  <= dec_rf_we;
            op_pc     <= dec_pc;
            op_ine    <= dec_ine;
            br_target <= target;
        end
    end

endmodule

//--- logic/issue_buffer.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module issue_buffer import decode_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               op_valid,
    input  alu_op_t            op_op,
    input  logic [`DATA_W-1:0] op_src1,
    input  logic [`DATA_W-1:0] op_src2,
    input  logic [`DATA_W-1:0] op_rkd,
    input  logic [`REG_AW-1:0] op_dest,
    input  logic               op_rf_we,
    input  logic [`DATA_W-1:0] op_pc,
    input  logic               op_ine,
    input  logic               out_credit,
    output logic               in_credit,
    output logic               out_valid,
    output alu_op_t            out_op,
    output logic [`DATA_W-1:0] out_src1,
    output logic [`DATA_W-1:0] out_src2,
    output logic [`DATA_W-1:0] out_rkd,
    output logic [`REG_AW-1:0] out_dest,
    output logic               out_rf_we,
    output logic [`DATA_W-1:0] out_pc,
    output logic               out_ine
);

    localparam int PTR_W   = $clog2(`ISSUE_DEPTH);
    localparam int OP_W    = $bits(alu_op_t);
    localparam int ENTRY_W = OP_W + 4 * `DATA_W + `REG_AW + 2;
    localparam int CRED_W  = 8;   // execute may bank credits ahead of items

    logic [ENTRY_W-1:0] mem [`ISSUE_DEPTH];
    logic [ENTRY_W-1:0] head;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic [CRED_W-1:0]  exec_credits;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`ISSUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // fetch credits bound the items in flight, so no full check
    assign push      = op_valid;
    assign pop       = out_valid;
    assign out_valid = (count != '0) && (exec_credits != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {op_op, op_src1, op_src2, op_rkd, op_dest, op_rf_we, op_pc, op_ine};
        end
    end

    assign head   = mem[rd_ptr];
    assign out_op = alu_op_t'(head[ENTRY_W-1 -: OP_W]);
    assign {out_src1, out_src2, out_rkd, out_dest, out_rf_we, out_pc, out_ine} =
        head[ENTRY_W-OP_W-1:0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            exec_credits <= '0;
            in_credit    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count        <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
            exec_credits <= exec_credits + {{(CRED_W-1){1'b0}}, out_credit}
                                         - {{(CRED_W-1){1'b0}}, pop};
            in_credit    <= pop;   // slot freed, hand it back to fetch
        end
    end

endmodule

//--- logic/decode_top.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_top import decode_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  logic [31:0]        in_inst,
    input  logic [`DATA_W-1:0] in_pc,
    input  logic               out_credit,
    input  logic               wb_we,
    input  logic [`REG_AW-1:0] wb_addr,
    input  logic [`DATA_W-1:0] wb_data,
    output logic               in_credit,
    output logic               br_valid,
    output logic [`DATA_W-1:0] br_target,
    output logic               out_valid,
    output alu_op_t            out_op,
    output logic [`DATA_W-1:0] out_src1,
    output logic [`DATA_W-1:0] out_src2,
    output logic [`DATA_W-1:0] out_rkd,
    output logic [`REG_AW-1:0] out_dest,
    output logic               out_rf_we,
    output logic [`DATA_W-1:0] out_pc,
    output logic               out_ine
);

    // decoder to operand stage
    logic               dec_valid;
    logic [`DATA_W-1:0] dec_pc;
    alu_op_t            dec_op;
    br_kind_t           dec_br;
    logic [`REG_AW-1:0] dec_rj;
    logic [`REG_AW-1:0] dec_rkd_addr;
    logic               dec_src1_is_pc;
    logic               dec_src2_is_imm;
    logic [`DATA_W-1:0] dec_imm;
    logic [`DATA_W-1:0] dec_br_offs;
    logic [`REG_AW-1:0] dec_dest;
    logic               dec_rf_we;
    logic               dec_ine;

    // operand stage to issue buffer
    logic               op_valid;
    alu_op_t            op_op;
    logic [`DATA_W-1:0] op_src1;
    logic [`DATA_W-1:0] op_src2;
    logic [`DATA_W-1:0] op_rkd;
    logic [`REG_AW-1:0] op_dest;
    logic               op_rf_we;
    logic [`DATA_W-1:0] op_pc;
    logic               op_ine;

    inst_decoder u_inst_decoder (.*);

    operand_stage u_operand_stage (.*);

    issue_buffer u_issue_buffer (.*);

endmodule

//--- test/decode_sva.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module issue_buffer_checks (
    input logic                            clk,
    input logic                            resetn,
    input logic [$clog2(`ISSUE_DEPTH):0]   count,
    input logic                            out_credit,
    input logic                            push,
    input logic                            pop
);

    int granted;   // execute credits not yet spent

    always_ff @(posedge clk) begin
        if (!resetn) begin
            granted <= 0;
        end else begin
            granted <= granted + (out_credit ? 1 : 0) - (pop ? 1 : 0);
        end
    end

    occupancy_bounded: assert property (
        @(posedge clk) disable iff (!resetn) count <= `ISSUE_DEPTH
    ) else $error("issue buffer occupancy above depth");

    // execute must have granted a credit first
    issue_needs_credit: assert property (
        @(posedge clk) disable iff (!resetn) pop |-> granted > 0
    ) else $error("item issued without an execute credit");

    no_write_when_full: assert property (
        @(posedge clk) disable iff (!resetn) push |-> count < `ISSUE_DEPTH
    ) else $error("item written into a full issue buffer");

endmodule

bind issue_buffer issue_buffer_checks chk0 (
    .clk        (clk),
    .resetn     (resetn),
    .count      (count),
    .out_credit (out_credit),
    .push       (push),
    .pop        (pop)
);

//--- test/decode_tb.sv
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_tb import decode_pkg::*; ();

    localparam int NROWS = 35;
    localparam int MID_ROW = 33;   // r0 and r2 rewritten before this row
    localparam int WATCHDOG_NS = (NROWS * 60 + 100) * 20;
    localparam logic [31:0] PC_BASE = 32'h1c00_0000;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        alu_op_t     op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] rkd;
        logic        chk_rkd;
        logic [4:0]  dest;
        logic        we;
        logic        ine;
        logic        taken;
        logic [31:0] target;
    } row_t;

    logic clk, resetn, in_valid, out_credit, wb_we;
    logic [31:0] in_inst, in_pc, wb_data;
    logic [4:0] wb_addr;
    logic in_credit, br_valid, out_valid, out_rf_we, out_ine;
    logic [31:0] br_target, out_src1, out_src2, out_rkd, out_pc;
    logic [4:0] out_dest;
    alu_op_t out_op;

    row_t rows [NROWS];
    int nrows = 0;
    logic [31:0] pc = PC_BASE;
    int errors = 0;
    int sent = 0;
    int returned = 0;
    int issued = 0;
    int cur_row = -1;
    int stage1 = -1;
    int stage2 = -1;
    integer seed;

    decode_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] enc_3r(input int f, input int rk, input int rj, input int rd);
        return {6'h00, 4'h0, 2'h1, 5'(f), 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_sh(input int f, input int ui5, input int rj, input int rd);
        return {6'h00, 4'h1, 2'h0, 5'(f), 5'(ui5), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [3:0] op4, input logic [11:0] i12,
                                             input int rj, input int rd);
        return {6'h00, op4, i12, 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_ri20(input logic [5:0] opc, input logic [19:0] i20,
                                             input int rd);
        return {opc, 1'b0, i20, 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_br16(input logic [5:0] opc, input logic [15:0] offs,
                                             input int rj, input int rd);
        return {opc, offs, 5'(rj), 5'(rd)};
    endfunction

    // offs[25:16] lands in the low ten bits
    function automatic logic [31:0] enc_br26(input logic [5:0] opc, input logic [25:0] offs);
        return {opc, offs[15:0], offs[25:16]};
    endfunction

    task automatic add_row(input logic [31:0] inst, input alu_op_t op, input logic [31:0] src1,
                           input logic [31:0] src2, input logic [31:0] rkd, input int chk_rkd,
                           input int dest, input int we, input int ine, input int taken,
                           input logic [31:0] target);
        rows[nrows] = '{inst, pc, op, src1, src2, rkd, chk_rkd != 0, 5'(dest), we != 0,
                        ine != 0, taken != 0, target};
        nrows++;
        pc = pc + 32'h4;
    endtask

    task automatic compare_field(input string name, input int row, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERROR %s row %0d: got %h expected %h", name, row, got, exp);
        end
    endtask

    task automatic write_back(input int addr, input logic [31:0] data);
        wb_we = 1'b1;
        wb_addr = 5'(addr);
        wb_data = data;
        @(negedge clk);
        wb_we = 1'b0;
    endtask

    task automatic build_table();
        add_row(enc_3r(5'h00, 2, 1, 7), OP_ADD, 32'h10, 32'h3, 32'h3, 1, 7, 1, 0, 0, 0);
        add_row(enc_3r(5'h02, 1, 3, 8), OP_SUB, 32'hfffffff0, 32'h10, 32'h10, 1, 8, 1, 0, 0, 0);
        add_row(enc_3r(5'h04, 2, 3, 9), OP_SLT, 32'hfffffff0, 32'h3, 32'h3, 1, 9, 1, 0, 0, 0);
        add_row(enc_3r(5'h05, 6, 5, 10), OP_SLTU, 32'h80000000, 32'h7, 32'h7, 1, 10, 1, 0, 0, 0);
        add_row(enc_3r(5'h08, 2, 1, 11), OP_NOR, 32'h10, 32'h3, 32'h3, 1, 11, 1, 0, 0, 0);
        add_row(enc_3r(5'h09, 4, 1, 12), OP_AND, 32'h10, 32'h10, 32'h10, 1, 12, 1, 0, 0, 0);
        add_row(enc_3r(5'h0a, 6, 2, 13), OP_OR, 32'h3, 32'h7, 32'h7, 1, 13, 1, 0, 0, 0);
        add_row(enc_3r(5'h0b, 2, 6, 14), OP_XOR, 32'h7, 32'h3, 32'h3, 1, 14, 1, 0, 0, 0);
        add_row(enc_3r(5'h0e, 2, 6, 15), OP_SLL, 32'h7, 32'h3, 32'h3, 1, 15, 1, 0, 0, 0);
        add_row(enc_3r(5'h0f, 2, 5, 16), OP_SRL, 32'h80000000, 32'h3, 32'h3, 1, 16, 1, 0, 0, 0);
        add_row(enc_3r(5'h10, 2, 5, 17), OP_SRA, 32'h80000000, 32'h3, 32'h3, 1, 17, 1, 0, 0, 0);
        add_row(enc_sh(5'h01, 4, 6, 18), OP_SLL, 32'h7, 32'h4, 32'h10, 1, 18, 1, 0, 0, 0);
        add_row(enc_sh(5'h09, 1, 5, 19), OP_SRL, 32'h80000000, 32'h1, 32'h10, 1, 19, 1, 0, 0, 0);
        add_row(enc_sh(5'h11, 4, 3, 20), OP_SRA, 32'hfffffff0, 32'h4, 32'h10, 1, 20, 1, 0, 0, 0);
        add_row(enc_ri12(4'ha, 12'hfe0, 1, 21), OP_ADD, 32'h10, 32'hffffffe0, 32'h0, 1, 21,
                1, 0, 0, 0);
        add_row(enc_ri12(4'h8, 12'h001, 3, 22), OP_SLT, 32'hfffffff0, 32'h1, 32'h10, 1, 22,
                1, 0, 0, 0);
        add_row(enc_ri12(4'h9, 12'h802, 6, 23), OP_SLTU, 32'h7, 32'hfffff802, 32'h3, 1, 23,
                1, 0, 0, 0);
        add_row(enc_ri12(4'hd, 12'h803, 3, 24), OP_AND, 32'hfffffff0, 32'h803, 32'hfffffff0, 1,
                24, 1, 0, 0, 0);
        add_row(enc_ri12(4'he, 12'hf05, 2, 25), OP_OR, 32'h3, 32'hf05, 32'h80000000, 1, 25,
                1, 0, 0, 0);
        add_row(enc_ri12(4'hf, 12'h006, 1, 26), OP_XOR, 32'h10, 32'h6, 32'h7, 1, 26, 1, 0, 0, 0);
        add_row(enc_ri20(`OPC_LU12I, 20'h12345, 27), OP_LUI, 32'h80000000, 32'h12345000, 0, 0,
                27, 1, 0, 0, 0);
        add_row(enc_ri20(`OPC_PCADDU12I, 20'h00002, 28), OP_ADD, pc, 32'h2000, 0, 0, 28,
                1, 0, 0, 0);
        // conditional branches, rd is the second compare source
        add_row(enc_br16(`OPC_BR_BASE + 6'd3, 16'h0008, 1, 4), OP_ADD, 32'h10, 32'h10, 32'h10, 1,
                4, 0, 0, 1, pc + 32'h20);
        add_row(enc_br16(`OPC_BR_BASE + 6'd4, 16'h0008, 1, 4), OP_ADD, 32'h10, 32'h10, 32'h10, 1,
                4, 0, 0, 0, 0);
        add_row(enc_br16(`OPC_BR_BASE + 6'd5, 16'hfffc, 3, 2), OP_ADD, 32'hfffffff0, 32'h3, 32'h3,
                1, 2, 0, 0, 1, pc - 32'h10);
        add_row(enc_br16(`OPC_BR_BASE + 6'd7, 16'h0004, 3, 2), OP_ADD, 32'hfffffff0, 32'h3, 32'h3,
                1, 2, 0, 0, 0, 0);
        add_row(enc_br16(`OPC_BR_BASE + 6'd6, 16'h0004, 2, 3), OP_ADD, 32'h3, 32'hfffffff0,
                32'hfffffff0, 1, 3, 0, 0, 1, pc + 32'h10);
        add_row(enc_br16(`OPC_BR_BASE + 6'd8, 16'h0002, 6, 2), OP_ADD, 32'h7, 32'h3, 32'h3, 1,
                2, 0, 0, 1, pc + 32'h8);
        add_row(enc_br26(`OPC_BR_BASE + 6'd1, 26'h100), OP_ADD, 0, 0, 0, 1, 0, 0, 0, 1,
                pc + 32'h400);
        add_row(enc_br26(`OPC_BR_BASE + 6'd2, 26'h40), OP_ADD, pc, 32'h4, 0, 1, `LINK_REG, 1, 0, 1,
                pc + 32'h100);
        add_row(enc_br16(`OPC_BR_BASE, 16'h0010, 6, 22), OP_ADD, pc, 32'h4, 0, 0, 22, 1, 0, 1,
                32'h47);
        // unknown words
        add_row(32'hfc000000, OP_ADD, 0, 0, 0, 1, 0, 0, 1, 0, 0);
        add_row(enc_3r(5'h1f, 2, 1, 3), OP_ADD, 32'h10, 32'h3, 32'h3, 1, 3, 0, 1, 0, 0);
        // after r0 and r2 are rewritten
        add_row(enc_3r(5'h00, 0, 2, 29), OP_ADD, 32'h55, 0, 0, 1, 29, 1, 0, 0, 0);
        add_row(enc_3r(5'h0a, 2, 0, 30), OP_OR, 0, 32'h55, 32'h55, 1, 30, 1, 0, 0, 0);
    endtask

    // fetch side bookkeeping and the branch timing pipeline
    always @(posedge clk) begin
        if (resetn) begin
            if (in_valid) sent++;
            if (in_credit) returned++;
            assert (returned <= issued) else begin
                errors++;
                $display("in_credit returned before the matching item issued");
            end
            stage2 = stage1;
            stage1 = in_valid ? cur_row : -1;
        end
    end

    always @(negedge clk) begin
        out_credit = (($random(seed) & 32'h3) == 32'h0);
    end

    always @(negedge clk) begin
        if (resetn && stage2 >= 0) begin
            compare_field("br_valid", stage2, 32'(br_valid), 32'(rows[stage2].taken));
            if (rows[stage2].taken) begin
                compare_field("br_target", stage2, br_target, rows[stage2].target);
            end
        end else if (resetn) begin
            compare_field("br_valid", -1, 32'(br_valid), 32'h0);
        end
    end

    // scoreboard in table order
    always @(negedge clk) begin
        if (resetn && out_valid) begin
            if (issued >= nrows) begin
                errors++;
                $display("item issued beyond the end of the table");
            end else begin
                compare_field("out_op", issued, 32'(out_op), 32'(rows[issued].op));
                compare_field("out_src1", issued, out_src1, rows[issued].src1);
                compare_field("out_src2", issued, out_src2, rows[issued].src2);
                if (rows[issued].chk_rkd) begin
                    compare_field("out_rkd", issued, out_rkd, rows[issued].rkd);
                end
                compare_field("out_dest", issued, 32'(out_dest), 32'(rows[issued].dest));
                compare_field("out_rf_we", issued, 32'(out_rf_we), 32'(rows[issued].we));
                compare_field("out_ine", issued, 32'(out_ine), 32'(rows[issued].ine));
                compare_field("out_pc", issued, out_pc, rows[issued].pc);
            end
            issued++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired with %0d of %0d items issued", issued, nrows);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        seed = 32'h74d6_f2b7;
        resetn = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        out_credit = 1'b0;
        wb_we = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        build_table();
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        write_back(1, 32'h10);
        write_back(2, 32'h3);
        write_back(3, 32'hfffffff0);
        write_back(4, 32'h10);
        write_back(5, 32'h80000000);
        write_back(6, 32'h7);
        repeat (3) begin
            compare_field("out_valid", -1, 32'(out_valid), 32'h0);
            compare_field("br_valid", -1, 32'(br_valid), 32'h0);
            compare_field("in_credit", -1, 32'(in_credit), 32'h0);
            @(negedge clk);
        end

        for (int i = 0; i < nrows; i++) begin
            if (i == MID_ROW) begin
                while (issued < i) @(negedge clk);
                write_back(0, 32'hdead);   // r0 must stay zero
                write_back(2, 32'h55);
            end
            while (sent - returned >= `ISSUE_DEPTH) @(negedge clk);
            in_valid = 1'b1;
            in_inst = rows[i].inst;
            in_pc = rows[i].pc;
            cur_row = i;
            @(negedge clk);
            in_valid = 1'b0;
        end

        while (issued < nrows) @(negedge clk);
        repeat (4) @(negedge clk);
        compare_field("in_credit_total", -1, 32'(returned), 32'(issued));

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/decode_pkg.sv
logic/regfile.sv
logic/inst_decoder.sv
logic/operand_stage.sv
logic/issue_buffer.sv
logic/decode_top.sv
test/decode_sva.sv
test/decode_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module decode_tb -f filelist.f -o decode_sim

# keep the simulator status out of the way, the log decides
./obj_dir/decode_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^All tests passed$" sim.log; then
    exit 0
else
    exit 1
fi
